// File: sources.f
+incdir+design
design/aib_bscan_pkg.sv
design/aib_io_bscan_cell.sv
design/aib_bscan_chain.sv
design/bscan_instr_ctrl.sv
design/aib_bscan_top.sv
tests/aib_bscan_chk.sv
tests/aib_bscan_tb.sv

// File: Makefile
# Verilator build and run for the boundary-scan testbench
VERILATOR ?= verilator
TOP       ?= aib_bscan_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh tests/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/aib_bscan_tb.sv
/* random-pin testbench with a cycle model of the whole column; pins and scan data
   change on falling edges, outputs are compared just before each rising edge */
`timescale 1ns/1ps
`include "aib_bscan_settings.svh"

module aib_bscan_tb
   import aib_bscan_pkg::*;
;
   localparam int NCH   = `AIB_BSCAN_NUM_CH;
   localparam int CHAIN = NCH * `AIB_BSCAN_CELL_BITS;  // 48 bits for 4 channels
   localparam int SCHED = 180;                         // planned cycles of all tests
   localparam int LIMIT = 4 * SCHED;

   logic          jtag_clkdr_in;
   logic          rst_n;
   bscan_instr_e  ir_code;
   logic          ir_strobe;
   logic          rst_val;
   logic          scan_en;
   logic          scan_in;
   tx_pins_t      adap_tx   [NCH];
   aib_rx_pins_t  aib_rx    [NCH];
   rstb_pair_t    adap_rstb [NCH];
   logic          scan_out;
   tx_pins_t      aib_tx    [NCH];
   adap_rx_pins_t adap_rx   [NCH];
   rstb_pair_t    aib_rstb  [NCH];
   logic          clkdr_out;
   logic          clkdr_outn;

   logic [31:0] lfsr = 32'h6f2480da;
   int          cyc_cnt = 0;

   // model state, the chain image is tx then rx per channel
   logic [6:0]  m_tx [NCH];
   logic [4:0]  m_rx [NCH];
   logic        m_n  [NCH];   // falling-edge copy of rx bit 0
   bscan_ctrl_t m_ctrl;

   aib_bscan_top aib_bscan_top_inst (.*);

   bind aib_bscan_top aib_bscan_chk chk_inst (
      .jtag_clkdr_in (jtag_clkdr_in),
      .rst_n         (rst_n),
      .ctrl          (ctrl),
      .adap_tx       (adap_tx),
      .aib_tx        (aib_tx),
      .adap_rstb     (adap_rstb),
      .aib_rstb      (aib_rstb),
      .clkdr_outn    (clkdr_outn)
   );

   always #5 jtag_clkdr_in = ~jtag_clkdr_in;

   always @(posedge jtag_clkdr_in)
   begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", LIMIT);
         $display("Errors found");
         $fatal(1, "timeout");
      end
   end

   // bound checker failures
   always @(aib_bscan_top_inst.chk_inst.fail_cnt)
   begin
      if (aib_bscan_top_inst.chk_inst.fail_cnt != 0)
      begin
         $display("Assertion failed in the bound checker at %0t", $time);
         $display("Errors found");
         $fatal(1, "assertion failed");
      end
   end

   // taps 32, 22, 2, 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
         r = {r[30:0], lfsr_bit()};
      return r;
   endfunction

   function automatic bscan_ctrl_t decode_instr(input bscan_instr_e code, input logic rv);
      bscan_ctrl_t c;
      c      = '0;
      c.rstb = rv;
      c.mode    = (code == INSTR_EXTEST) || (code == INSTR_INTEST) ||
                  (code == INSTR_EXTEST_RST);
      c.intest  = (code == INSTR_INTEST);
      c.rstb_en = (code == INSTR_EXTEST_RST);
      return c;
   endfunction

   // adapter RX as odat0, odat1, odat_asyn
   function automatic logic [2:0] exp_adap_rx(input int ch);
      if (m_ctrl.intest)
         return {m_rx[ch][4], m_rx[ch][3], m_rx[ch][0]};
      return {aib_rx[ch].odat0, aib_rx[ch].odat1, aib_rx[ch].odat_asyn};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "check failed");
      end
   endtask

   task automatic model_rise();
      logic [6:0] ntx [NCH];
      logic [4:0] nrx [NCH];
      logic       sin;
      logic [2:0] arx;
      for (int ch = 0; ch < NCH; ch++)
      begin
         sin = (ch == 0) ? scan_in : m_n[ch-1];
         arx = exp_adap_rx(ch);
         if (scan_en)
         begin
            ntx[ch] = {sin, m_tx[ch][6:1]};
            nrx[ch] = {m_tx[ch][0], m_rx[ch][4:1]};
         end
         else
         begin
            ntx[ch] = m_ctrl.intest ? 7'(adap_tx[ch]) : m_tx[ch];
            nrx[ch] = {arx[2], arx[1], aib_rx[ch].oclkn, aib_rx[ch].oclkp, arx[0]};
         end
      end
      m_tx = ntx;
      m_rx = nrx;
      if (ir_strobe)
         m_ctrl = decode_instr(ir_code, rst_val);
   endtask

   task automatic model_fall();
      for (int ch = 0; ch < NCH; ch++)
         m_n[ch] = m_rx[ch][0];
   endtask

   task automatic check_outputs();
      logic [6:0] etx;
      logic [1:0] erst;
      #4;  // just before the rising edge
      for (int ch = 0; ch < NCH; ch++)
      begin
         etx  = m_ctrl.mode ? m_tx[ch] : 7'(adap_tx[ch]);
         erst = m_ctrl.rstb_en ? {m_ctrl.rstb, m_ctrl.rstb} : 2'(adap_rstb[ch]);
         check_val($sformatf("aib_tx[%0d]", ch), 32'(aib_tx[ch]), 32'(etx));
         check_val($sformatf("adap_rx[%0d]", ch), 32'(adap_rx[ch]), 32'(exp_adap_rx(ch)));
         check_val($sformatf("aib_rstb[%0d]", ch), 32'(aib_rstb[ch]), 32'(erst));
      end
      check_val("scan_out", 32'(scan_out), 32'(m_n[NCH-1]));
      check_val("clkdr_out", 32'(clkdr_out), 32'(jtag_clkdr_in));
      check_val("clkdr_outn", 32'(clkdr_outn), 32'(!jtag_clkdr_in));
   endtask

   task automatic drive_pins();
      logic [31:0] r;
      for (int ch = 0; ch < NCH; ch++)
      begin
         r             = rand_bits(7);
         adap_tx[ch]   = tx_pins_t'(r[6:0]);
         r             = rand_bits(5);
         aib_rx[ch]    = aib_rx_pins_t'(r[4:0]);
         r             = rand_bits(2);
         adap_rstb[ch] = rstb_pair_t'(r[1:0]);
      end
   endtask

   // called at a falling edge, returns at the next one
   task automatic run_cycle(input logic se, input logic si);
      scan_en = se;
      scan_in = si;
      check_outputs();
      @(posedge jtag_clkdr_in);
      model_rise();
      #1;  // forwarded clocks in the high phase
      check_val("clkdr_out", 32'(clkdr_out), 32'(jtag_clkdr_in));
      check_val("clkdr_outn", 32'(clkdr_outn), 32'(!jtag_clkdr_in));
      @(negedge jtag_clkdr_in);
      model_fall();
   endtask

   task automatic load_instr(input bscan_instr_e code, input logic rv);
      ir_code   = code;
      rst_val   = rv;
      ir_strobe = 1'b1;
      run_cycle(1'b0, 1'b0);
      ir_strobe = 1'b0;
   endtask

   task automatic shift_random(input int n);
      for (int i = 0; i < n; i++)
         run_cycle(1'b1, lfsr_bit());
   endtask

   initial
   begin
      jtag_clkdr_in = 1'b0;
      rst_n         = 1'b0;
      ir_code       = INSTR_FUNCTIONAL;
      ir_strobe     = 1'b0;
      rst_val       = 1'b0;
      scan_en       = 1'b0;
      scan_in       = 1'b0;
      m_ctrl        = '0;
      for (int ch = 0; ch < NCH; ch++)
      begin
         adap_tx[ch]   = '0;
         aib_rx[ch]    = '0;
         adap_rstb[ch] = '0;
         m_tx[ch]      = '0;
         m_rx[ch]      = '0;
         m_n[ch]       = 1'b0;
      end
      repeat (2) @(posedge jtag_clkdr_in);
      @(negedge jtag_clkdr_in);
      rst_n = 1'b1;

      // functional pass-through
      for (int i = 0; i < 6; i++)
      begin
         drive_pins();
         run_cycle(1'b0, 1'b0);
      end

      // extest drive, then capture and shift-out
      load_instr(INSTR_EXTEST, 1'b0);
      shift_random(CHAIN);
      drive_pins();
      run_cycle(1'b0, 1'b0);
      shift_random(CHAIN);

      // intest, capture of the adapter TX pins
      load_instr(INSTR_INTEST, 1'b0);
      shift_random(4);
      drive_pins();
      run_cycle(1'b0, 1'b0);
      shift_random(CHAIN);

      // reset override with both values, then release
      for (int k = 0; k < 2; k++)
      begin
         load_instr(INSTR_EXTEST_RST, 1'(k));
         for (int i = 0; i < 4; i++)
         begin
            drive_pins();
            run_cycle(1'b0, 1'b0);
         end
      end
      load_instr(INSTR_FUNCTIONAL, 1'b0);
      for (int i = 0; i < 4; i++)
      begin
         drive_pins();
         run_cycle(1'b0, 1'b0);
      end

      $display("No errors");
      $finish;
   end

endmodule

// File: tests/aib_bscan_chk.sv
/* bound to aib_bscan_top; pin checks are sampled on the rising edge, where
   the falling-edge stimulus is stable */
`timescale 1ns/1ps
`include "aib_bscan_settings.svh"

module aib_bscan_chk
   import aib_bscan_pkg::*;
(
   input logic        jtag_clkdr_in,
   input logic        rst_n,
   input bscan_ctrl_t ctrl,
   input tx_pins_t    adap_tx   [`AIB_BSCAN_NUM_CH],
   input tx_pins_t    aib_tx    [`AIB_BSCAN_NUM_CH],
   input rstb_pair_t  adap_rstb [`AIB_BSCAN_NUM_CH],
   input rstb_pair_t  aib_rstb  [`AIB_BSCAN_NUM_CH],
   input logic        clkdr_outn
);

   int fail_cnt = 0;  // failed assertions so far, watched by the testbench

   // decoder comes out of reset functional
   ctrl_in_reset: assert property (@(posedge jtag_clkdr_in) !rst_n |-> ctrl == '0)
   else
   begin
      fail_cnt++;
      $error("controls not zero during reset");
   end

   clk_inverse: assert property (@(posedge jtag_clkdr_in) clkdr_outn != jtag_clkdr_in)
   else
   begin
      fail_cnt++;
      $error("clkdr_outn is not the inverted scan clock");
   end

   for (genvar g = 0; g < `AIB_BSCAN_NUM_CH; g++)
   begin : g_ch
      tx_passthru: assert property (@(posedge jtag_clkdr_in) disable iff (!rst_n)
         !ctrl.mode |-> aib_tx[g] == adap_tx[g])
      else
      begin
         fail_cnt++;
         $error("aib_tx differs from adap_tx in functional mode");
      end

      rst_override: assert property (@(posedge jtag_clkdr_in) disable iff (!rst_n)
         aib_rstb[g] == (ctrl.rstb_en ? rstb_pair_t'({ctrl.rstb, ctrl.rstb}) : adap_rstb[g]))
      else
      begin
         fail_cnt++;
         $error("AIB reset pair does not follow the override rule");
      end
   end

endmodule

// File: design/aib_bscan_top.sv
/* boundary-scan subsystem for one AIB column; the TAP is external and only
   provides the instruction load and the shift enable */
`timescale 1ns/1ps
`include "aib_bscan_settings.svh"

module aib_bscan_top
   import aib_bscan_pkg::*;
(
   input  logic          jtag_clkdr_in,
   input  logic          rst_n,
   input  bscan_instr_e  ir_code,
   input  logic          ir_strobe,
   input  logic          rst_val,
   input  logic          scan_en,
   input  logic          scan_in,
   input  tx_pins_t      adap_tx   [`AIB_BSCAN_NUM_CH],
   input  aib_rx_pins_t  aib_rx    [`AIB_BSCAN_NUM_CH],
   input  rstb_pair_t    adap_rstb [`AIB_BSCAN_NUM_CH],
   output logic          scan_out,
   output tx_pins_t      aib_tx    [`AIB_BSCAN_NUM_CH],
   output adap_rx_pins_t adap_rx   [`AIB_BSCAN_NUM_CH],
   output rstb_pair_t    aib_rstb  [`AIB_BSCAN_NUM_CH],
   output logic          clkdr_out,
   output logic          clkdr_outn
);

   bscan_ctrl_t ctrl;  // decoded controls to every cell

   bscan_instr_ctrl instr_ctrl_inst (
      .jtag_clkdr_in (jtag_clkdr_in),
      .rst_n         (rst_n),
      .ir_code       (ir_code),
      .ir_strobe     (ir_strobe),
      .rst_val       (rst_val),
      .ctrl          (ctrl)
   );

   aib_bscan_chain chain_inst (
      .jtag_clkdr_in (jtag_clkdr_in),
      .rst_n         (rst_n),
      .ctrl          (ctrl),
      .scan_en       (scan_en),
      .scan_in       (scan_in),
      .adap_tx       (adap_tx),
      .aib_rx        (aib_rx),
      .adap_rstb     (adap_rstb),
      .scan_out      (scan_out),
      .aib_tx        (aib_tx),
      .adap_rx       (adap_rx),
      .aib_rstb      (aib_rstb),
      .clkdr_out     (clkdr_out),
      .clkdr_outn    (clkdr_outn)
   );

endmodule

// File: design/bscan_instr_ctrl.sv
/* instruction register loaded by a one-cycle strobe with no back-pressure;
   unknown codes decode as functional */
`timescale 1ns/1ps

module bscan_instr_ctrl
   import aib_bscan_pkg::*;
(
   input  logic         jtag_clkdr_in,
   input  logic         rst_n,
   input  bscan_instr_e ir_code,    // valid with ir_strobe
   input  logic         ir_strobe,  // single cycle load
   input  logic         rst_val,    // reset override value, latched with the code
   output bscan_ctrl_t  ctrl
);

   bscan_instr_e instr_q;
   logic         rstb_q;

   always_ff @(posedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         instr_q <= INSTR_FUNCTIONAL;
         rstb_q  <= 1'b0;
      end
      else if (ir_strobe)
      begin
         instr_q <= ir_code;
         rstb_q  <= rst_val;
      end
   end

   // decode from the held instruction, so controls change one edge after the strobe
   always_comb
   begin
      ctrl      = '0;
      ctrl.rstb = rstb_q;
      case (instr_q)
         INSTR_EXTEST:
            ctrl.mode = 1'b1;
         INSTR_INTEST:
         begin
            ctrl.mode   = 1'b1;
            ctrl.intest = 1'b1;
         end
         INSTR_EXTEST_RST:
         begin
            ctrl.mode    = 1'b1;
            ctrl.rstb_en = 1'b1;  // drive both AIB resets from rstb
         end
         default:
            ctrl.mode = 1'b0;     // functional and unused codes
      endcase
   end

endmodule

// File: design/aib_bscan_chain.sv
/* channel 0 is nearest scan_in; total length is 12 bits per channel and
   the forwarded scan clock is taken from channel 0 only */
`timescale 1ns/1ps
`include "aib_bscan_settings.svh"

module aib_bscan_chain
   import aib_bscan_pkg::*;
(
   input  logic          jtag_clkdr_in,
   input  logic          rst_n,
   input  bscan_ctrl_t   ctrl,                        // shared by all cells
   input  logic          scan_en,
   input  logic          scan_in,
   input  tx_pins_t      adap_tx   [`AIB_BSCAN_NUM_CH],
   input  aib_rx_pins_t  aib_rx    [`AIB_BSCAN_NUM_CH],
   input  rstb_pair_t    adap_rstb [`AIB_BSCAN_NUM_CH],
   output logic          scan_out,                    // from the last cell
   output tx_pins_t      aib_tx    [`AIB_BSCAN_NUM_CH],
   output adap_rx_pins_t adap_rx   [`AIB_BSCAN_NUM_CH],
   output rstb_pair_t    aib_rstb  [`AIB_BSCAN_NUM_CH],
   output logic          clkdr_out,
   output logic          clkdr_outn
);

   logic [`AIB_BSCAN_NUM_CH:0]   scan_link;   // link i feeds cell i
   logic [`AIB_BSCAN_NUM_CH-1:0] clkdr_ch;
   logic [`AIB_BSCAN_NUM_CH-1:0] clkdr_n_ch;

   assign scan_link[0] = scan_in;

   for (genvar g = 0; g < `AIB_BSCAN_NUM_CH; g++)
   begin : g_ch
      aib_io_bscan_cell cell_inst (
         .jtag_clkdr_in (jtag_clkdr_in),
         .rst_n         (rst_n),
         .ctrl          (ctrl),
         .scan_en       (scan_en),
         .scan_in       (scan_link[g]),
         .adap_tx       (adap_tx[g]),
         .aib_rx        (aib_rx[g]),
         .adap_rstb     (adap_rstb[g]),
         .scan_out      (scan_link[g+1]),
         .aib_tx        (aib_tx[g]),
         .adap_rx       (adap_rx[g]),
         .aib_rstb      (aib_rstb[g]),
         .clkdr_out     (clkdr_ch[g]),
         .clkdr_outn    (clkdr_n_ch[g])
      );
   end

   assign scan_out   = scan_link[`AIB_BSCAN_NUM_CH];
   assign clkdr_out  = clkdr_ch[0];    // same net in every cell
   assign clkdr_outn = clkdr_n_ch[0];

endmodule

// File: design/aib_io_bscan_cell.sv
/* one AIB channel of boundary scan; scan_out is retimed on the falling edge so the
   next cell samples it with margin, giving 12 rising edges per cell */
`timescale 1ns/1ps
`include "aib_bscan_settings.svh"

module aib_io_bscan_cell
   import aib_bscan_pkg::*;
(
   input  logic          jtag_clkdr_in,  // boundary-scan clock
   input  logic          rst_n,
   input  bscan_ctrl_t   ctrl,
   input  logic          scan_en,        // shift dr, active high
   input  logic          scan_in,
   input  tx_pins_t      adap_tx,        // TX from the adapter
   input  aib_rx_pins_t  aib_rx,         // RX from the AIB
   input  rstb_pair_t    adap_rstb,      // resets from the adapter
   output logic          scan_out,
   output tx_pins_t      aib_tx,         // TX to the AIB
   output adap_rx_pins_t adap_rx,        // RX to the adapter
   output rstb_pair_t    aib_rstb,       // resets to the AIB
   output logic          clkdr_out,      // scan clock to the rest of the column
   output logic          clkdr_outn      // inverted, for the sync DDR TX
);

   logic [`AIB_BSCAN_TX_BITS-1:0]   tx_reg;
   logic [`AIB_BSCAN_RX_BITS-1:0]   rx_reg;
   logic                            rx_nreg;    // falling-edge copy of rx_reg[0]
   logic [`AIB_BSCAN_CELL_BITS-1:0] shift_nxt;  // tx and rx shifted as one register
   logic [`AIB_BSCAN_TX_BITS-1:0]   tx_cap;
   logic [`AIB_BSCAN_RX_BITS-1:0]   rx_cap;

   // AIB TX side, register drives the pads in extest and intest
   assign aib_tx = ctrl.mode ? tx_pins_t'(tx_reg) : adap_tx;

   // adapter RX side, intest feeds the core from the RX register
   always_comb
   begin
      if (ctrl.intest)
      begin
         adap_rx.odat0     = rx_reg[4];
         adap_rx.odat1     = rx_reg[3];
         adap_rx.odat_asyn = rx_reg[0];
      end
      else
      begin
         adap_rx.odat0     = aib_rx.odat0;
         adap_rx.odat1     = aib_rx.odat1;
         adap_rx.odat_asyn = aib_rx.odat_asyn;
      end
   end

   // both AIB resets follow the override value together
   assign aib_rstb = ctrl.rstb_en ? rstb_pair_t'({ctrl.rstb, ctrl.rstb}) : adap_rstb;

   // plain buffer and inverter here, a clock cell in the netlist
   assign clkdr_out  = jtag_clkdr_in;
   assign clkdr_outn = ~jtag_clkdr_in;

   // msb first: scan_in enters tx[6], tx[0] feeds rx[4], rx[0] drops off
   assign shift_nxt = {scan_in, tx_reg, rx_reg[`AIB_BSCAN_RX_BITS-1:1]};

   // tx only captures under intest, else holds the shifted pattern
   assign tx_cap = ctrl.intest ? adap_tx : tx_reg;

   // data bits are taken after the intest mux, clocks raw from the AIB
   assign rx_cap = {adap_rx.odat0, adap_rx.odat1, aib_rx.oclkn, aib_rx.oclkp,
                    adap_rx.odat_asyn};

   always_ff @(posedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_reg <= '0;
         rx_reg <= '0;
      end
      else if (scan_en)
      begin
         tx_reg <= shift_nxt[`AIB_BSCAN_CELL_BITS-1:`AIB_BSCAN_RX_BITS];
         rx_reg <= shift_nxt[`AIB_BSCAN_RX_BITS-1:0];
      end
      else
      begin
         tx_reg <= tx_cap;
         rx_reg <= rx_cap;  // capture every non-shift cycle
      end
   end

   // half-cycle retime toward the next cell
   always_ff @(negedge jtag_clkdr_in or negedge rst_n)
   begin
      if (!rst_n)
         rx_nreg <= 1'b0;
      else
         rx_nreg <= rx_reg[0];
   end

   assign scan_out = rx_nreg;

endmodule

// File: design/aib_bscan_pkg.sv
/* pin-group structs and scan controls; struct field order is the scan register
   order, MSB first, and must not be rearranged */
package aib_bscan_pkg;

   typedef logic [2:0] rxen_t;  // receive-enable code to the AIB buffer

   // adapter-side TX inputs and AIB-side TX outputs, same layout
   typedef struct packed {
      logic  dat0;       // sdr data 0
      logic  dat1;       // sdr data 1
      logic  async_data; // async data path
      logic  txen;       // output enable
      rxen_t rxen;
   } tx_pins_t;

   // receive pins as they come out of the AIB
   typedef struct packed {
      logic odat0;
      logic odat1;
      logic oclkn;     // diff clock, captured only
      logic oclkp;
      logic odat_asyn;
   } aib_rx_pins_t;

   // receive pins handed on to the adapter, clocks not forwarded
   typedef struct packed {
      logic odat0;
      logic odat1;
      logic odat_asyn;
   } adap_rx_pins_t;

   typedef struct packed {
      logic anlg;  // analog reset, active low
      logic dig;   // digital reset, active low
   } rstb_pair_t;

   // controls from the instruction decoder to every cell
   typedef struct packed {
      logic mode;     // drive AIB TX from the TX register
      logic intest;   // drive adapter RX from the RX register, capture adapter TX
      logic rstb_en;  // override both AIB resets
      logic rstb;     // override value
   } bscan_ctrl_t;

   typedef enum logic [2:0] {
      INSTR_FUNCTIONAL = 3'd0,
      INSTR_EXTEST     = 3'd1,
      INSTR_INTEST     = 3'd2,
      INSTR_EXTEST_RST = 3'd3   // extest plus reset override
   } bscan_instr_e;

endpackage

// File: design/aib_bscan_settings.svh
/* per-column sizing for the boundary-scan chain; the cell widths are fixed by the
   pin structs in the package, so only the channel count may be changed */
`ifndef AIB_BSCAN_SETTINGS_SVH
`define AIB_BSCAN_SETTINGS_SVH

// number of AIB channels in the column, one scan cell each
`define AIB_BSCAN_NUM_CH 4

// TX register: dat0, dat1, async data, txen, rxen[2:0]
`define AIB_BSCAN_TX_BITS 7

// RX register: odat0, odat1, oclkn, oclkp, async data
`define AIB_BSCAN_RX_BITS 5

// full cell length seen by the scan path
`define AIB_BSCAN_CELL_BITS (`AIB_BSCAN_TX_BITS + `AIB_BSCAN_RX_BITS)

`endif
